// ==== logic/icache_consts.svh ====
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// direct-mapped geometry, one word per line
`define ICACHE_LINES 16
`define ICACHE_INDEX_BITS 4
`define ICACHE_TAG_BITS 26

// width of a fetched word and of a byte address
`define ICACHE_WORD_BITS 32

`endif

// ==== logic/icache_pkg.sv ====
`include "icache_consts.svh"

package icache_pkg;

    // byte address split for lookup
    typedef struct packed {
        logic [`ICACHE_TAG_BITS-1:0]   tag;
        logic [`ICACHE_INDEX_BITS-1:0] index;
        logic [1:0]                    offset;
    } icache_fields_t;

    // same word, seen raw for the memory side or split for the arrays
    typedef union packed {
        logic [`ICACHE_WORD_BITS-1:0] raw;
        icache_fields_t               fields;
    } icache_addr_t;

    typedef enum logic [1:0] {
        idle,
        compare,
        refill,
        reply
    } lookup_state_t;

endpackage

// ==== logic/icache_addr_decode.sv ====
module icache_addr_decode
    import icache_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         cpu_req,
    input  logic [31:0]  cpu_addr,
    input  logic         reply_done,
    output logic         addr_valid,
    output icache_addr_t addr
);

    logic busy;
    logic capture;

    // first sight of a request once the previous one has fully retired
    assign capture = cpu_req && (!busy || reply_done);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy       <= 1'b0;
            addr_valid <= 1'b0;
        end
        else
        begin
            addr_valid <= 1'b0;
            if (capture)
            begin
                busy       <= 1'b1;
                addr_valid <= 1'b1;
            end
            else if (reply_done)
            begin
                busy <= 1'b0;
            end
        end
    end

    // held until reply_done so lookup and refill see a stable word
    always_ff @(posedge clk)
    begin
        if (capture)
        begin
            addr.raw <= cpu_addr;
        end
    end

endmodule

// ==== logic/icache_lookup.sv ====
`include "icache_consts.svh"

module icache_lookup
    import icache_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flush,
    input  logic                         addr_valid,
    input  icache_addr_t                 addr,
    output logic                         refill_start,
    output logic [`ICACHE_WORD_BITS-1:0] refill_addr,
    input  logic                         refill_done,
    input  logic [`ICACHE_WORD_BITS-1:0] refill_data,
    output logic                         reply_start,
    output logic [`ICACHE_WORD_BITS-1:0] reply_data
);

    lookup_state_t state;

    logic [`ICACHE_LINES-1:0]     valid;
    logic [`ICACHE_TAG_BITS-1:0]  tag_mem [`ICACHE_LINES];
    logic [`ICACHE_WORD_BITS-1:0] data_mem [`ICACHE_LINES];

    logic hit;
    logic flush_pend;
    logic filled;
    logic fill_write;

    assign hit = valid[addr.fields.index] && (tag_mem[addr.fields.index] == addr.fields.tag);

    assign fill_write = (state == refill) && refill_done;

    // memory side always reads a word-aligned address
    assign refill_addr  = {addr.raw[`ICACHE_WORD_BITS-1:2], 2'b00};
    assign refill_start = (state == compare) && !hit;

    // hit answers straight from compare, a miss answers once the line is written
    assign reply_start = ((state == compare) && hit) || ((state == reply) && filled);
    assign reply_data  = data_mem[addr.fields.index];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= idle;
            valid      <= '0;
            flush_pend <= 1'b0;
            filled     <= 1'b0;
        end
        else
        begin
            filled <= 1'b0;
            case (state)
                idle:
                begin
                    if (flush || flush_pend)
                    begin
                        valid      <= '0;
                        flush_pend <= 1'b0;
                    end
                    if (addr_valid)
                    begin
                        state <= compare;
                    end
                end
                compare:
                begin
                    state <= hit ? reply : refill;
                end
                refill:
                begin
                    if (refill_done)
                    begin
                        valid[addr.fields.index] <= 1'b1;
                        filled                   <= 1'b1;
                        state                    <= reply;
                    end
                end
                default:
                begin
                    state <= idle;
                end
            endcase

            // flush seen mid-transaction is held for idle
            if (flush && (state != idle))
            begin
                flush_pend <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill_write)
        begin
            tag_mem[addr.fields.index]  <= addr.fields.tag;
            data_mem[addr.fields.index] <= refill_data;
        end
    end

endmodule

// ==== logic/icache_refill.sv ====
`include "icache_consts.svh"

module icache_refill (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         refill_start,
    input  logic [`ICACHE_WORD_BITS-1:0] refill_addr,
    output logic                         refill_done,
    output logic [`ICACHE_WORD_BITS-1:0] refill_data,
    output logic                         mem_req,
    output logic [`ICACHE_WORD_BITS-1:0] mem_addr,
    input  logic                         mem_ack,
    input  logic [`ICACHE_WORD_BITS-1:0] mem_data
);

    logic wait_low;
    logic launch;
    logic take;

    // no memory transaction in flight
    assign launch = refill_start && !mem_req && !wait_low;

    // first cycle ack is seen with the request still up
    assign take = mem_req && mem_ack;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mem_req     <= 1'b0;
            wait_low    <= 1'b0;
            refill_done <= 1'b0;
        end
        else
        begin
            refill_done <= 1'b0;
            if (launch)
            begin
                mem_req <= 1'b1;
            end
            else if (take)
            begin
                mem_req  <= 1'b0;
                wait_low <= 1'b1;
            end
            else if (wait_low && !mem_ack)
            begin
                // memory has released, handshake back to idle
                wait_low    <= 1'b0;
                refill_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (launch)
        begin
            mem_addr <= refill_addr;
        end
        if (take)
        begin
            refill_data <= mem_data;
        end
    end

endmodule

// ==== logic/icache_respond.sv ====
module icache_respond (
    input  logic        clk,
    input  logic        rst,
    input  logic        reply_start,
    input  logic [31:0] reply_data,
    input  logic        cpu_req,
    output logic        cpu_ack,
    output logic [31:0] cpu_data,
    output logic        reply_done
);

    logic release_ack;

    // fetch unit has dropped its request
    assign release_ack = cpu_ack && !cpu_req;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cpu_ack    <= 1'b0;
            reply_done <= 1'b0;
        end
        else
        begin
            reply_done <= 1'b0;
            if (reply_start)
            begin
                cpu_ack <= 1'b1;
            end
            else if (release_ack)
            begin
                cpu_ack    <= 1'b0;
                reply_done <= 1'b1;
            end
        end
    end

    // word stays put for as long as ack is high
    always_ff @(posedge clk)
    begin
        if (reply_start)
        begin
            cpu_data <= reply_data;
        end
    end

endmodule

// ==== logic/icache_top.sv ====
`include "icache_consts.svh"

module icache_top
    import icache_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flush,
    input  logic                         cpu_req,
    input  logic [`ICACHE_WORD_BITS-1:0] cpu_addr,
    output logic                         cpu_ack,
    output logic [`ICACHE_WORD_BITS-1:0] cpu_data,
    output logic                         mem_req,
    output logic [`ICACHE_WORD_BITS-1:0] mem_addr,
    input  logic                         mem_ack,
    input  logic [`ICACHE_WORD_BITS-1:0] mem_data
);

    logic                         addr_valid;
    icache_addr_t                 addr;
    logic                         refill_start;
    logic [`ICACHE_WORD_BITS-1:0] refill_addr;
    logic                         refill_done;
    logic [`ICACHE_WORD_BITS-1:0] refill_data;
    logic                         reply_start;
    logic [`ICACHE_WORD_BITS-1:0] reply_data;
    logic                         reply_done;

    icache_addr_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .cpu_req    (cpu_req),
        .cpu_addr   (cpu_addr),
        .reply_done (reply_done),
        .addr_valid (addr_valid),
        .addr       (addr)
    );

    icache_lookup u_lookup (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .addr_valid   (addr_valid),
        .addr         (addr),
        .refill_start (refill_start),
        .refill_addr  (refill_addr),
        .refill_done  (refill_done),
        .refill_data  (refill_data),
        .reply_start  (reply_start),
        .reply_data   (reply_data)
    );

    // memory side transaction for misses
    icache_refill u_refill (
        .clk          (clk),
        .rst          (rst),
        .refill_start (refill_start),
        .refill_addr  (refill_addr),
        .refill_done  (refill_done),
        .refill_data  (refill_data),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .mem_ack      (mem_ack),
        .mem_data     (mem_data)
    );

    icache_respond u_respond (
        .clk         (clk),
        .rst         (rst),
        .reply_start (reply_start),
        .reply_data  (reply_data),
        .cpu_req     (cpu_req),
        .cpu_ack     (cpu_ack),
        .cpu_data    (cpu_data),
        .reply_done  (reply_done)
    );

endmodule

// ==== test/icache_checker.sv ====
module icache_checker (
    input logic        clk,
    input logic        rst,
    input logic        cpu_req,
    input logic [31:0] cpu_addr,
    input logic        cpu_ack,
    input logic [31:0] cpu_data,
    input logic        mem_req,
    input logic [31:0] mem_addr,
    input logic [31:0] exp_data,
    input logic        exp_hit
);

    int data_errors = 0;
    int refill_errors = 0;
    int protocol_errors = 0;
    int responses = 0;

    logic req_q = 1'b0;
    logic ack_q = 1'b0;
    logic mem_q = 1'b0;
    logic answered = 1'b0;
    int   mem_rises = 0;
    int   edges = 0;

    always @(posedge clk)
    begin
        if (!rst)
        begin
            // new fetch starts its own refill and latency count
            if (cpu_req && !req_q)
            begin
                mem_rises = 0;
                edges     = 0;
                answered  = 1'b0;
            end
            else
            begin
                edges++;
            end

            if (mem_req && !mem_q)
            begin
                mem_rises++;
                if (mem_addr != {cpu_addr[31:2], 2'b00})
                begin
                    $display("Fail t=%0t mem_addr expected %h got %h",
                             $time, {cpu_addr[31:2], 2'b00}, mem_addr);
                    refill_errors++;
                end
                if (mem_addr[1:0] != 2'b00)
                begin
                    $display("memory address has a nonzero byte offset at t=%0t", $time);
                    protocol_errors++;
                end
            end
            if (mem_req && !cpu_req)
            begin
                $display("memory request raised with no fetch in progress at t=%0t", $time);
                protocol_errors++;
            end

            if (cpu_ack && !ack_q)
            begin
                responses++;
                if (!req_q)
                begin
                    $display("cpu_ack rose without a fetch request at t=%0t", $time);
                    protocol_errors++;
                end
                if (answered)
                begin
                    $display("second acknowledge for one fetch at t=%0t", $time);
                    protocol_errors++;
                end
                answered = 1'b1;
                if (cpu_data !== exp_data)
                begin
                    $display("Fail t=%0t cpu_data expected %h got %h", $time, exp_data, cpu_data);
                    data_errors++;
                end
                // a hit never touches memory, a miss reads exactly once
                if (mem_rises != (exp_hit ? 0 : 1))
                begin
                    $display("Fail t=%0t mem_req rises expected %0d got %0d",
                             $time, exp_hit ? 0 : 1, mem_rises);
                    refill_errors++;
                end
                if (exp_hit && edges != 3)
                begin
                    $display("Fail t=%0t cpu_ack edge expected 3 got %0d", $time, edges);
                    protocol_errors++;
                end
            end

            if (ack_q && !cpu_ack && req_q)
            begin
                $display("cpu_ack dropped while cpu_req was still high at t=%0t", $time);
                protocol_errors++;
            end
        end
        req_q = cpu_req;
        ack_q = cpu_ack;
        mem_q = mem_req;
    end

endmodule

// ==== test/icache_tb.sv ====
module icache_tb;

    localparam int MAX_VEC = 64;

    logic        clk;
    logic        rst;
    logic        flush;
    logic        cpu_req;
    logic [31:0] cpu_addr;
    logic        cpu_ack;
    logic [31:0] cpu_data;
    logic        mem_req;
    logic [31:0] mem_addr;
    logic        mem_ack;
    logic [31:0] mem_data;
    logic [31:0] exp_data;
    logic        exp_hit;

    // op, address, expected word and hit flag for each operation
    logic [31:0] vec_mem [4*MAX_VEC];
    int          vec_count;
    logic        loaded;
    int          fetches;
    int          other_errors;

    icache_top UUT (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .cpu_req  (cpu_req),
        .cpu_addr (cpu_addr),
        .cpu_ack  (cpu_ack),
        .cpu_data (cpu_data),
        .mem_req  (mem_req),
        .mem_addr (mem_addr),
        .mem_ack  (mem_ack),
        .mem_data (mem_data)
    );

    icache_checker u_check (
        .clk      (clk),
        .rst      (rst),
        .cpu_req  (cpu_req),
        .cpu_addr (cpu_addr),
        .cpu_ack  (cpu_ack),
        .cpu_data (cpu_data),
        .mem_req  (mem_req),
        .mem_addr (mem_addr),
        .exp_data (exp_data),
        .exp_hit  (exp_hit)
    );

    always
    begin
        #5 clk = ~clk;
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [31:0] vec_word(input int op_num, input int col);
        return vec_mem[8'(4 * op_num + col)];
    endfunction

    // fetch side holds the request a random while after the acknowledge
    task automatic fetch_word(input logic [31:0] addr);
        int unsigned hold;
        cpu_addr = addr;
        cpu_req  = 1'b1;
        while (!cpu_ack)
        begin
            step();
        end
        hold = $urandom % 4;
        repeat (hold) step();
        cpu_req = 1'b0;
        while (cpu_ack)
        begin
            step();
        end
    endtask

    task automatic flush_all();
        flush = 1'b1;
        step();
        flush = 1'b0;
    endtask

    // memory returns the inverse of the word address
    initial
    begin
        int unsigned delay;
        mem_ack  = 1'b0;
        mem_data = '0;
        forever
        begin
            step();
            if (mem_req)
            begin
                delay = $urandom % 6;
                repeat (delay) step();
                mem_data = ~{mem_addr[31:2], 2'b00};
                mem_ack  = 1'b1;
                step();
                while (mem_req)
                begin
                    step();
                end
                mem_ack = 1'b0;
            end
        end
    end

    initial
    begin
        wait (loaded);
        repeat (8 + vec_count * 40) @(posedge clk);
        $display("timeout: vectors not finished after %0d cycles", 8 + vec_count * 40);
        $display("=== FAIL ===");
        $finish;
    end

    initial
    begin
        int i;
        int total;
        clk          = 1'b0;
        rst          = 1'b1;
        flush        = 1'b0;
        cpu_req      = 1'b0;
        cpu_addr     = '0;
        exp_data     = '0;
        exp_hit      = 1'b0;
        loaded       = 1'b0;
        fetches      = 0;
        other_errors = 0;
        void'($urandom(32'hffa3_adf9));
        $readmemh("test/icache_vectors.txt", vec_mem);
        vec_count = 0;
        while (vec_count < MAX_VEC && vec_word(vec_count, 0) != 32'h2)
        begin
            vec_count++;
        end
        loaded = 1'b1;
        if (vec_count == 0)
        begin
            $display("no operations found in the vector file");
            other_errors++;
        end

        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
        step();

        for (i = 0; i < vec_count; i++)
        begin
            if (vec_word(i, 0) == 32'h1)
            begin
                flush_all();
            end
            else
            begin
                exp_data = vec_word(i, 2);
                exp_hit  = vec_word(i, 3) != 32'h0;
                fetch_word(vec_word(i, 1));
                fetches++;
            end
        end
        step();
        step();

        if (u_check.responses != fetches)
        begin
            $display("%0d fetches issued but %0d acknowledged", fetches, u_check.responses);
            other_errors++;
        end
        total = u_check.data_errors + u_check.refill_errors + u_check.protocol_errors
              + other_errors;
        $display("errors: data %0d refill %0d protocol %0d other %0d",
                 u_check.data_errors, u_check.refill_errors, u_check.protocol_errors,
                 other_errors);
        if (total == 0)
        begin
            $display("=== PASS ===");
        end
        else
        begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+logic
logic/icache_pkg.sv
logic/icache_addr_decode.sv
logic/icache_lookup.sv
logic/icache_refill.sv
logic/icache_respond.sv
logic/icache_top.sv
test/icache_checker.sv
test/icache_tb.sv

// ==== Makefile ====
TOP = icache_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f flist.f --top-module icache_top
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing -f flist.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q '^=== PASS ===$$' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== test/icache_vectors.txt ====
// columns: op, byte address, expected word, expected hit (all hex)
// op 0 is a fetch, 1 a flush, 2 ends the list
0 00000000 ffffffff 0
0 00000004 fffffffb 0
0 00000008 fffffff7 0
0 0000000c fffffff3 0
0 00000000 ffffffff 1
0 00000008 fffffff7 1
0 00000005 fffffffb 1
0 0000000f fffffff3 1
0 0000000a fffffff7 1
0 12345670 edcba98f 0
0 80000014 7fffffeb 0
0 12345672 edcba98f 1
0 00000040 ffffffbf 0
0 00000000 ffffffff 0
0 00000040 ffffffbf 0
0 00000000 ffffffff 0
0 00000043 ffffffbf 0
0 00000041 ffffffbf 1
0 dead0014 2152ffeb 0
0 80000014 7fffffeb 0
0 80000016 7fffffeb 1
1 00000000 00000000 0
0 00000004 fffffffb 0
0 12345670 edcba98f 0
0 00000004 fffffffb 1
0 00000040 ffffffbf 0
1 00000000 00000000 0
0 00000040 ffffffbf 0
0 00000040 ffffffbf 1
0 fffffffd 00000003 0
0 0badf00c f4520ff3 0
0 0000000c fffffff3 0
0 0badf00e f4520ff3 0
2 00000000 00000000 0
